// File: Makefile
VERILATOR = verilator
FLAGS = --binary --assert --timing -Wno-fatal
TOP = tb_mania_core
FILELIST = vlog.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: logic/bram_loader.sv
// BRAM loader: pulls one SD stream byte by byte and writes assembled words to a BRAM
`timescale 1ns/100ps

module bram_loader #(
	parameter int ADDR_WIDTH = 13,
	parameter int BYTES_PER_WORD = 3,
	parameter logic [7:0] AUX_INFO = 8'h00,
	parameter type word_t = logic [23:0]
) (
	input  logic CLK,
	input  logic RESET_L,
	input  logic start,
	input  logic [7:0] song_selection,
	input  logic [mania_pkg::BYTE_WIDTH-1:0] data_in,
	input  logic data_ready,
	input  logic transmit_finished,
	output logic restart,
	output logic [7:0] init_index,
	output logic [7:0] init_aux_info,
	output logic request_data,
	output logic [ADDR_WIDTH-1:0] addr_w,
	output word_t data_w,
	output logic en_w,
	output logic done
);

	localparam int WORD_BITS = $bits(word_t);
	localparam int CNT_WIDTH = $clog2(BYTES_PER_WORD + 1);

	typedef enum logic [1:0] {ld_idle, ld_first, ld_wait, ld_check} ld_state_t;

	ld_state_t ld_state;
	logic [CNT_WIDTH-1:0] byte_cnt; // bytes already in the current word
	logic last_byte;

	assign init_aux_info = AUX_INFO; // fixed per stream
	assign last_byte = byte_cnt == CNT_WIDTH'(BYTES_PER_WORD - 1);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			ld_state <= ld_idle;
			restart <= 1'b0;
			request_data <= 1'b0;
			en_w <= 1'b0;
			done <= 1'b0;
			addr_w <= '0;
			byte_cnt <= '0;
			init_index <= '0;
		end else begin
			restart <= 1'b0; // all strobes default low
			request_data <= 1'b0;
			en_w <= 1'b0;
			done <= 1'b0;
			if (en_w)
				addr_w <= addr_w + 1'b1; // next word slot
			case (ld_state)
				ld_idle: if (start) begin
					restart <= 1'b1;
					init_index <= song_selection;
					addr_w <= '0;
					byte_cnt <= '0;
					ld_state <= ld_first;
				end
				ld_first: begin // stream may still look finished from the last owner
					request_data <= 1'b1;
					ld_state <= ld_wait;
				end
				ld_wait: if (data_ready) begin
					byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
					en_w <= last_byte;
					ld_state <= ld_check;
				end
				default: begin
					// idle between requests
					if (transmit_finished) begin
						done <= 1'b1;
						ld_state <= ld_idle;
					end else begin
						request_data <= 1'b1;
						ld_state <= ld_wait;
					end
				end
			endcase
		end
	end

	// first byte ends up least significant
	always_ff @(posedge CLK) begin
		if (ld_state == ld_wait && data_ready)
			data_w <= word_t'({data_in, data_w[WORD_BITS-1:mania_pkg::BYTE_WIDTH]});
	end

	// pre-reader only answers a request this loader has outstanding
	assert property (@(posedge CLK) disable iff (!RESET_L)
		(ld_state != ld_idle && data_ready) |-> (ld_state == ld_wait && !request_data))
		else $error("data_ready without an outstanding request");

	assert property (@(posedge CLK) disable iff (!RESET_L) en_w |=> !en_w)
		else $error("en_w held for two cycles");

endmodule

// File: logic/level_table_scan.sv
// level table scan: reads each level's size word and derives its base address in the beatmap
`timescale 1ns/100ps

module level_table_scan #(
	parameter int ADDR_WIDTH = 13,
	parameter int NUM_LEVELS = 4
) (
	input  logic CLK,
	input  logic RESET_L,
	input  logic start,
	input  mania_pkg::beatmap_word_t rd_data,
	output logic [ADDR_WIDTH-1:0] rd_addr,
	output logic rd_en,
	output logic [NUM_LEVELS-1:0][ADDR_WIDTH-1:0] level_size,
	output logic [NUM_LEVELS-1:0][ADDR_WIDTH-1:0] level_base,
	output logic done
);

	localparam int LVL_WIDTH = $clog2(NUM_LEVELS);

	logic busy;
	logic [1:0] phase; // 0 issue, 3 sample
	logic [LVL_WIDTH-1:0] level;
	logic last_level;

	assign last_level = level == LVL_WIDTH'(NUM_LEVELS - 1);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			busy <= 1'b0;
			phase <= '0;
			level <= '0;
			rd_addr <= '0;
			rd_en <= 1'b0;
			done <= 1'b0;
			level_size <= '0;
			level_base <= '0;
		end else begin
			done <= busy && phase == 2'd3 && last_level;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					phase <= '0;
					level <= '0;
				end
			end else begin
				if (phase == 2'd0) begin
					// size word sits just before each level's data
					if (level == '0)
						rd_addr <= '0;
					else
						rd_addr <= level_base[level - 1'b1] + level_size[level - 1'b1];
					rd_en <= 1'b1;
				end else if (phase == 2'd3) begin
					// two cycles of slack on the read latency
					level_size[level] <= rd_data[ADDR_WIDTH-1:0];
					level_base[level] <= rd_addr + 1'b1;
					rd_en <= 1'b0;
					if (last_level)
						busy <= 1'b0;
					else
						level <= level + 1'b1;
				end
				phase <= phase + 1'b1;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (!RESET_L) rd_en |-> busy)
		else $error("beatmap read outside a scan");

endmodule

// File: logic/load_sequencer.sv
// start-up sequencer: skin load, beatmap load, level scan, then standby; owns the pre-reader mux
`timescale 1ns/100ps

module load_sequencer (
	input  logic CLK,
	input  logic RESET_L,
	input  logic skin_done,
	input  logic beatmap_done,
	input  logic scan_done,
	input  logic skin_restart,
	input  logic [7:0] skin_init_index,
	input  logic [7:0] skin_init_aux_info,
	input  logic skin_request_data,
	input  logic beatmap_restart,
	input  logic [7:0] beatmap_init_index,
	input  logic [7:0] beatmap_init_aux_info,
	input  logic beatmap_request_data,
	output logic skin_start,
	output logic beatmap_start,
	output logic scan_start,
	output logic [7:0] pre_init_index,
	output logic [7:0] pre_init_aux_info,
	output logic pre_restart,
	output logic pre_request_data,
	output logic [mania_pkg::STATE_WIDTH-1:0] state
);

	logic [mania_pkg::STATE_WIDTH-1:0] next_state;

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			state <= mania_pkg::S_INIT;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			mania_pkg::S_INIT:           next_state = mania_pkg::S_LOAD_SKIN;
			mania_pkg::S_LOAD_SKIN:      next_state = mania_pkg::S_W_LOAD_SKIN;
			mania_pkg::S_W_LOAD_SKIN:
				next_state = skin_done ? mania_pkg::S_LOAD_BEATMAP : mania_pkg::S_W_LOAD_SKIN;
			mania_pkg::S_LOAD_BEATMAP:   next_state = mania_pkg::S_W_LOAD_BEATMAP;
			mania_pkg::S_W_LOAD_BEATMAP:
				next_state = beatmap_done ? mania_pkg::S_SCAN_LEVELS : mania_pkg::S_W_LOAD_BEATMAP;
			mania_pkg::S_SCAN_LEVELS:    next_state = mania_pkg::S_W_SCAN_LEVELS;
			mania_pkg::S_W_SCAN_LEVELS:
				next_state = scan_done ? mania_pkg::S_STANDBY : mania_pkg::S_W_SCAN_LEVELS;
			mania_pkg::S_STANDBY:        next_state = mania_pkg::S_STANDBY; // stays for good
			default:                     next_state = mania_pkg::S_INIT;
		endcase
	end

	// one-cycle start states
	assign skin_start    = state == mania_pkg::S_LOAD_SKIN;
	assign beatmap_start = state == mania_pkg::S_LOAD_BEATMAP;
	assign scan_start    = state == mania_pkg::S_SCAN_LEVELS;

	// pre-reader belongs to whichever loader is running
	always_comb begin
		pre_init_index = '0;
		pre_init_aux_info = '0;
		pre_restart = 1'b0;
		pre_request_data = 1'b0;
		case (state)
			mania_pkg::S_LOAD_SKIN, mania_pkg::S_W_LOAD_SKIN: begin
				pre_init_index = skin_init_index;
				pre_init_aux_info = skin_init_aux_info;
				pre_restart = skin_restart;
				pre_request_data = skin_request_data;
			end
			mania_pkg::S_LOAD_BEATMAP, mania_pkg::S_W_LOAD_BEATMAP: begin
				pre_init_index = beatmap_init_index;
				pre_init_aux_info = beatmap_init_aux_info;
				pre_restart = beatmap_restart;
				pre_request_data = beatmap_request_data;
			end
			default: ;
		endcase
	end

	assert property (@(posedge CLK) disable iff (!RESET_L)
		$onehot0({skin_start, beatmap_start, scan_start}))
		else $error("more than one start pulse");

endmodule

// File: logic/mania_core.sv
// mania core start-up loader: sequencer, skin and beatmap loaders, level table scan
`timescale 1ns/100ps

module mania_core (
	input  logic CLK,
	input  logic RESET_L,
	input  logic [7:0] song_selection, // held during use
	input  logic [mania_pkg::BYTE_WIDTH-1:0] pre_data_in,
	input  logic pre_data_ready,
	input  logic pre_transmit_finished,
	input  mania_pkg::beatmap_word_t db_data_out,
	output logic [7:0] pre_init_index,
	output logic [7:0] pre_init_aux_info,
	output logic pre_restart,
	output logic pre_request_data,
	output logic [mania_pkg::SKIN_ADDR_WIDTH-1:0] ds_addr_w,
	output mania_pkg::skin_word_t ds_data_in,
	output logic ds_en_w,
	output logic [mania_pkg::BEATMAP_ADDR_WIDTH-1:0] db_addr_w,
	output mania_pkg::beatmap_word_t db_data_in,
	output logic db_en_w,
	output logic [mania_pkg::BEATMAP_ADDR_WIDTH-1:0] db_addr_r,
	output logic db_en_r,
	output logic [mania_pkg::NUM_LEVELS-1:0][mania_pkg::BEATMAP_ADDR_WIDTH-1:0] level_size,
	output logic [mania_pkg::NUM_LEVELS-1:0][mania_pkg::BEATMAP_ADDR_WIDTH-1:0] level_base,
	output logic [mania_pkg::STATE_WIDTH-1:0] debug_state
);

	logic skin_start, skin_done, skin_restart, skin_request_data;
	logic [7:0] skin_init_index, skin_init_aux_info;
	logic beatmap_start, beatmap_done, beatmap_restart, beatmap_request_data;
	logic [7:0] beatmap_init_index, beatmap_init_aux_info;
	logic scan_start, scan_done;

	load_sequencer u_seq (
		.CLK, .RESET_L,
		.skin_done, .beatmap_done, .scan_done,
		.skin_restart, .skin_init_index, .skin_init_aux_info, .skin_request_data,
		.beatmap_restart, .beatmap_init_index, .beatmap_init_aux_info, .beatmap_request_data,
		.skin_start, .beatmap_start, .scan_start,
		.pre_init_index, .pre_init_aux_info, .pre_restart, .pre_request_data,
		.state(debug_state)
	);

	// .skin stream
	bram_loader #(
		.ADDR_WIDTH(mania_pkg::SKIN_ADDR_WIDTH), .BYTES_PER_WORD(mania_pkg::SKIN_BYTES),
		.AUX_INFO(mania_pkg::SKIN_AUX), .word_t(mania_pkg::skin_word_t)
	) u_skin_loader (
		.CLK, .RESET_L, .start(skin_start), .song_selection,
		.data_in(pre_data_in), .data_ready(pre_data_ready),
		.transmit_finished(pre_transmit_finished),
		.restart(skin_restart), .init_index(skin_init_index),
		.init_aux_info(skin_init_aux_info), .request_data(skin_request_data),
		.addr_w(ds_addr_w), .data_w(ds_data_in), .en_w(ds_en_w), .done(skin_done)
	);

	// .beatmap stream
	bram_loader #(
		.ADDR_WIDTH(mania_pkg::BEATMAP_ADDR_WIDTH), .BYTES_PER_WORD(mania_pkg::BEATMAP_BYTES),
		.AUX_INFO(mania_pkg::BEATMAP_AUX), .word_t(mania_pkg::beatmap_word_t)
	) u_beatmap_loader (
		.CLK, .RESET_L, .start(beatmap_start), .song_selection,
		.data_in(pre_data_in), .data_ready(pre_data_ready),
		.transmit_finished(pre_transmit_finished),
		.restart(beatmap_restart), .init_index(beatmap_init_index),
		.init_aux_info(beatmap_init_aux_info), .request_data(beatmap_request_data),
		.addr_w(db_addr_w), .data_w(db_data_in), .en_w(db_en_w), .done(beatmap_done)
	);

	level_table_scan #(
		.ADDR_WIDTH(mania_pkg::BEATMAP_ADDR_WIDTH), .NUM_LEVELS(mania_pkg::NUM_LEVELS)
	) u_scan (
		.CLK, .RESET_L, .start(scan_start), .rd_data(db_data_out),
		.rd_addr(db_addr_r), .rd_en(db_en_r),
		.level_size, .level_base, .done(scan_done)
	);

endmodule

// File: logic/mania_pkg.sv
// mania core shared definitions: sequencer state codes, stream widths and per-stream constants
package mania_pkg;

	localparam int STATE_WIDTH = 16;

	// state codes count in decimal digits
	localparam logic [STATE_WIDTH-1:0] S_INIT           = 16'h0000;
	localparam logic [STATE_WIDTH-1:0] S_LOAD_SKIN      = 16'h0001;
	localparam logic [STATE_WIDTH-1:0] S_W_LOAD_SKIN    = 16'h0002;
	localparam logic [STATE_WIDTH-1:0] S_LOAD_BEATMAP   = 16'h0003;
	localparam logic [STATE_WIDTH-1:0] S_W_LOAD_BEATMAP = 16'h0004;
	localparam logic [STATE_WIDTH-1:0] S_SCAN_LEVELS    = 16'h0013;
	localparam logic [STATE_WIDTH-1:0] S_W_SCAN_LEVELS  = 16'h0014;
	localparam logic [STATE_WIDTH-1:0] S_STANDBY        = 16'h9999; // game idle

	localparam int BYTE_WIDTH = 8; // one SD byte

	localparam int SKIN_ADDR_WIDTH    = 15;
	localparam int BEATMAP_ADDR_WIDTH = 13;

	// bytes per BRAM word
	localparam int SKIN_BYTES    = 2;
	localparam int BEATMAP_BYTES = 3;

	// aux info sent to the pre-reader on restart
	localparam logic [7:0] SKIN_AUX    = 8'h80;
	localparam logic [7:0] BEATMAP_AUX = 8'h00;

	localparam int NUM_LEVELS = 4; // difficulty levels

	typedef logic [15:0] skin_word_t;
	typedef logic [23:0] beatmap_word_t;

endpackage

// File: test/sd_card_model.sv
// behavioral SD pre-reader: streams one byte image per aux code, answers requests after a delay
`timescale 1ns/100ps

module sd_card_model (
	input  logic CLK,
	input  logic RESET_L,
	input  logic restart,
	input  logic [7:0] aux_info,
	input  logic request_data,
	input  logic [1:0] reply_delay, // extra wait cycles for the next answer
	output logic [7:0] data_out,
	output logic data_ready,
	output logic transmit_finished
);

	logic [7:0] skin_image [256]; // filled by the testbench
	logic [7:0] beatmap_image [256];
	int skin_len = 0;
	int beatmap_len = 0;

	logic [7:0] byte_q = '0;
	logic ready_q = 1'b0;
	logic finished_q = 1'b0;
	logic use_skin = 1'b1;
	logic pending = 1'b0;
	logic [1:0] wait_cnt = '0;
	int pos = 0;

	assign data_out = byte_q;
	assign data_ready = ready_q;
	assign transmit_finished = finished_q;

	always @(posedge CLK) begin
		ready_q <= 1'b0;
		if (!RESET_L) begin
			pending <= 1'b0;
			finished_q <= 1'b0;
			pos <= 0;
		end else if (restart) begin
			use_skin <= aux_info == mania_pkg::SKIN_AUX; // pick the stream
			pos <= 0;
			pending <= 1'b0;
			finished_q <= 1'b0;
		end else if (request_data) begin
			pending <= 1'b1;
			wait_cnt <= reply_delay;
		end else if (pending) begin
			if (wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end else begin
				byte_q <= use_skin ? skin_image[pos] : beatmap_image[pos];
				ready_q <= 1'b1;
				pending <= 1'b0;
				pos <= pos + 1;
				finished_q <= pos + 1 >= (use_skin ? skin_len : beatmap_len); // image used up
			end
		end
	end

endmodule

// File: test/tb_clock.sv
// testbench clock and reset source: 100 ns clock, reset held low for the first cycles
`timescale 1ns/100ps

module tb_clock #(
	parameter int RESET_CYCLES = 10
) (
	output logic CLK,
	output logic RESET_L
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		RESET_L = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RESET_L <= 1'b1; // released on a rising edge
	end

endmodule

// File: test/tb_mania_core.sv
// testbench for the mania core start-up loader: BRAM models, SD stimulus and assertion checks
`timescale 1ns/100ps

module tb_mania_core;

	localparam int SKIN_LEN = 16; // skin image bytes
	localparam int SKIN_WORDS = SKIN_LEN / mania_pkg::SKIN_BYTES;
	localparam int AW = mania_pkg::BEATMAP_ADDR_WIDTH;
	localparam int NL = mania_pkg::NUM_LEVELS;

	logic CLK, RESET_L;
	logic [7:0] song_selection = '0;
	logic [7:0] pre_data_in, pre_init_index, pre_init_aux_info;
	logic pre_data_ready, pre_transmit_finished, pre_restart, pre_request_data;
	mania_pkg::beatmap_word_t db_data_out = '0;
	mania_pkg::beatmap_word_t db_data_in;
	logic [mania_pkg::SKIN_ADDR_WIDTH-1:0] ds_addr_w;
	mania_pkg::skin_word_t ds_data_in;
	logic ds_en_w, db_en_w, db_en_r;
	logic [AW-1:0] db_addr_w, db_addr_r;
	logic [NL-1:0][AW-1:0] level_size, level_base, exp_size, exp_base;
	logic [mania_pkg::STATE_WIDTH-1:0] debug_state;

	logic [1:0] reply_delay = '0;
	logic [31:0] lcg_state = 32'h780d;
	logic [7:0] song_pick;
	logic [7:0] skin_bytes [SKIN_LEN];
	logic [7:0] beatmap_bytes [256];
	int beatmap_len, beatmap_words;
	mania_pkg::skin_word_t skin_mem [SKIN_WORDS];
	mania_pkg::beatmap_word_t beatmap_mem [1 << AW];
	int skin_count = 0;
	int beatmap_count = 0;
	int err_cnt [1:5] = '{default: 0};
	int tests_passed = 0;
	int tests_failed = 0;
	bit images_built = 1'b0;

	tb_clock clk_gen (.CLK, .RESET_L);

	sd_card_model sd (
		.CLK, .RESET_L, .restart(pre_restart), .aux_info(pre_init_aux_info),
		.request_data(pre_request_data), .reply_delay, .data_out(pre_data_in),
		.data_ready(pre_data_ready), .transmit_finished(pre_transmit_finished)
	);

	mania_core UUT (.*);

	function automatic logic [23:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:8]; // low bits repeat too soon
	endfunction

	function automatic mania_pkg::skin_word_t skin_word(input int a);
		mania_pkg::skin_word_t w;
		for (int b = 0; b < mania_pkg::SKIN_BYTES; b++)
			w[8*b +: 8] = skin_bytes[a * mania_pkg::SKIN_BYTES + b];
		return w;
	endfunction

	function automatic mania_pkg::beatmap_word_t beatmap_word(input int a);
		mania_pkg::beatmap_word_t w;
		for (int b = 0; b < mania_pkg::BEATMAP_BYTES; b++)
			w[8*b +: 8] = beatmap_bytes[a * mania_pkg::BEATMAP_BYTES + b];
		return w;
	endfunction

	task automatic put_beatmap_word(input int a, input mania_pkg::beatmap_word_t w);
		for (int b = 0; b < mania_pkg::BEATMAP_BYTES; b++)
			beatmap_bytes[a * mania_pkg::BEATMAP_BYTES + b] = w[8*b +: 8]; // lsb first
	endtask

	task automatic build_images();
		int addr;
		int size;
		mania_pkg::beatmap_word_t w;
		song_pick = 8'(next_random() >> 16);
		for (int i = 0; i < SKIN_LEN; i++)
			skin_bytes[i] = 8'(next_random() >> 16);
		addr = 0;
		for (int lv = 0; lv < NL; lv++) begin
			size = 1 + int'(next_random() % 24'd20);
			exp_size[lv] = AW'(size);
			exp_base[lv] = (lv == 0) ? AW'(1) : exp_base[lv-1] + exp_size[lv-1] + AW'(1);
			w = next_random();
			w[AW-1:0] = AW'(size); // junk above the size field
			put_beatmap_word(addr, w);
			for (int k = 1; k <= size; k++)
				put_beatmap_word(addr + k, next_random());
			addr = addr + size + 1;
		end
		beatmap_words = addr;
		beatmap_len = addr * mania_pkg::BEATMAP_BYTES;
		for (int i = 0; i < SKIN_LEN; i++)
			sd.skin_image[i] = skin_bytes[i];
		for (int i = 0; i < beatmap_len; i++)
			sd.beatmap_image[i] = beatmap_bytes[i];
		sd.skin_len = SKIN_LEN;
		sd.beatmap_len = beatmap_len;
	endtask

	task automatic note_mismatch(input int test, input string sig,
		input logic [63:0] actual, input logic [63:0] expected);
		err_cnt[test]++;
		$display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, sig, actual, expected);
	endtask

	task automatic finish_test(input int test, input string name);
		if (err_cnt[test] == 0) begin
			tests_passed++;
			$display("test %0d %s: passed", test, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", test, name, err_cnt[test]);
		end
	endtask

	task automatic wait_for_state(input logic [mania_pkg::STATE_WIDTH-1:0] code);
		while (debug_state !== code)
			@(negedge CLK);
	endtask

	function automatic int total_errors();
		int sum;
		sum = 0;
		for (int t = 1; t <= 5; t++)
			sum += err_cnt[t];
		return sum;
	endfunction

	// skin and beatmap BRAMs, one cycle read latency
	always @(posedge CLK) begin
		if (ds_en_w) begin
			skin_mem[ds_addr_w] <= ds_data_in;
			skin_count <= skin_count + 1;
		end
		if (db_en_w) begin
			beatmap_mem[db_addr_w] <= db_data_in;
			beatmap_count <= beatmap_count + 1;
		end
		if (db_en_r)
			db_data_out <= beatmap_mem[db_addr_r];
		reply_delay <= 2'(next_random() >> 22);
	end

	// test 1
	assert property (@(posedge CLK) !RESET_L |=>
		{ds_en_w, db_en_w, db_en_r, pre_restart, pre_request_data} == 5'b0)
		else note_mismatch(1, "strobes in reset",
			$sampled({ds_en_w, db_en_w, db_en_r, pre_restart, pre_request_data}), 0);
	assert property (@(posedge CLK) $rose(RESET_L) |=> debug_state == mania_pkg::S_LOAD_SKIN)
		else note_mismatch(1, "debug_state", $sampled(debug_state), mania_pkg::S_LOAD_SKIN);

	// test 2
	assert property (@(posedge CLK) disable iff (!RESET_L)
		debug_state == mania_pkg::S_LOAD_SKIN |=>
		{pre_restart, pre_init_index, pre_init_aux_info} ==
		{1'b1, song_selection, mania_pkg::SKIN_AUX})
		else note_mismatch(2, "pre_restart/index/aux",
			$sampled({pre_restart, pre_init_index, pre_init_aux_info}),
			$sampled({1'b1, song_selection, mania_pkg::SKIN_AUX}));
	assert property (@(posedge CLK) disable iff (!RESET_L) ds_en_w |-> ds_addr_w == skin_count)
		else note_mismatch(2, "ds_addr_w", $sampled(ds_addr_w), $sampled(skin_count));
	assert property (@(posedge CLK) disable iff (!RESET_L)
		ds_en_w |-> ds_data_in == skin_word(ds_addr_w))
		else note_mismatch(2, "ds_data_in", $sampled(ds_data_in), skin_word($sampled(ds_addr_w)));
	assert property (@(posedge CLK) disable iff (!RESET_L)
		debug_state == mania_pkg::S_LOAD_BEATMAP |-> skin_count == SKIN_WORDS)
		else note_mismatch(2, "skin word count", $sampled(skin_count), SKIN_WORDS);

	// test 3
	assert property (@(posedge CLK) disable iff (!RESET_L)
		debug_state == mania_pkg::S_LOAD_BEATMAP |=>
		{pre_restart, pre_init_index, pre_init_aux_info} ==
		{1'b1, song_selection, mania_pkg::BEATMAP_AUX})
		else note_mismatch(3, "pre_restart/index/aux",
			$sampled({pre_restart, pre_init_index, pre_init_aux_info}),
			$sampled({1'b1, song_selection, mania_pkg::BEATMAP_AUX}));
	assert property (@(posedge CLK) disable iff (!RESET_L) db_en_w |-> db_addr_w == beatmap_count)
		else note_mismatch(3, "db_addr_w", $sampled(db_addr_w), $sampled(beatmap_count));
	assert property (@(posedge CLK) disable iff (!RESET_L)
		db_en_w |-> db_data_in == beatmap_word(db_addr_w))
		else note_mismatch(3, "db_data_in", $sampled(db_data_in),
			beatmap_word($sampled(db_addr_w)));
	assert property (@(posedge CLK) disable iff (!RESET_L) db_en_w |-> skin_count == SKIN_WORDS)
		else note_mismatch(3, "skin words before beatmap write", $sampled(skin_count), SKIN_WORDS);
	assert property (@(posedge CLK) disable iff (!RESET_L)
		debug_state == mania_pkg::S_SCAN_LEVELS |-> beatmap_count == beatmap_words)
		else note_mismatch(3, "beatmap word count", $sampled(beatmap_count), beatmap_words);

	// test 4
	assert property (@(posedge CLK) disable iff (!RESET_L)
		debug_state == mania_pkg::S_STANDBY |-> level_size == exp_size)
		else note_mismatch(4, "level_size", $sampled(level_size), exp_size);
	assert property (@(posedge CLK) disable iff (!RESET_L)
		debug_state == mania_pkg::S_STANDBY |-> level_base == exp_base)
		else note_mismatch(4, "level_base", $sampled(level_base), exp_base);

	// test 5
	assert property (@(posedge CLK) disable iff (!RESET_L)
		debug_state == mania_pkg::S_STANDBY |=> debug_state == mania_pkg::S_STANDBY)
		else note_mismatch(5, "debug_state", $sampled(debug_state), mania_pkg::S_STANDBY);
	assert property (@(posedge CLK) disable iff (!RESET_L)
		debug_state == mania_pkg::S_STANDBY |-> {pre_init_index, pre_init_aux_info, pre_restart,
		pre_request_data, ds_en_w, db_en_w, db_en_r} == '0)
		else note_mismatch(5, "pre outputs and enables", $sampled({pre_init_index,
			pre_init_aux_info, pre_restart, pre_request_data, ds_en_w, db_en_w, db_en_r}), 0);

	initial begin
		build_images();
		images_built = 1'b1;
		@(posedge CLK);
		song_selection <= song_pick; // held for the whole run
		wait (RESET_L === 1'b1);
		repeat (3) @(negedge CLK);
		finish_test(1, "reset values and first state");
		wait_for_state(mania_pkg::S_LOAD_BEATMAP);
		@(negedge CLK);
		// whole skin image must sit in the BRAM
		for (int k = 0; k < SKIN_WORDS; k++)
			assert (skin_mem[k] == skin_word(k))
				else note_mismatch(2, "skin_mem", skin_mem[k], skin_word(k));
		finish_test(2, "skin load");
		wait_for_state(mania_pkg::S_SCAN_LEVELS);
		@(negedge CLK);
		finish_test(3, "beatmap load");
		wait_for_state(mania_pkg::S_STANDBY);
		@(negedge CLK);
		finish_test(4, "level table scan");
		repeat (20) @(negedge CLK);
		finish_test(5, "standby hold");
		$display("tests passed: %0d, tests failed: %0d, check errors: %0d",
			tests_passed, tests_failed, total_errors());
		if (tests_failed == 0 && total_errors() == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// watchdog, scaled to the stream lengths
	initial begin
		int limit;
		wait (images_built);
		limit = 20 * (SKIN_LEN + beatmap_len + 4 * NL + 50);
		repeat (limit) @(posedge CLK);
		$display("watchdog: standby not reached and checked within %0d cycles", limit);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: vlog.f
logic/mania_pkg.sv
logic/bram_loader.sv
logic/load_sequencer.sv
logic/level_table_scan.sv
logic/mania_core.sv
test/tb_clock.sv
test/sd_card_model.sv
test/tb_mania_core.sv
